// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // access size, coded as the funct3 field of the load/store opcodes.
  typedef enum logic [2:0] {
    LDST_B  = 3'b000, // signed byte.
    LDST_H  = 3'b001, // signed halfword.
    LDST_W  = 3'b010, // full word.
    LDST_BU = 3'b100, // unsigned byte.
    LDST_HU = 3'b101  // unsigned halfword.
  } ldst_size_e;

  // request as the core pipeline presents it.
  // store data sits in the low bits of wd, lane placement is done by the lsu.
  typedef struct packed {
    logic        we;   // high for a store.
    ldst_size_e  size;
    logic [31:0] addr; // byte address.
    logic [31:0] wd;
  } core_req_t;

endpackage

`default_nettype wire

// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // request as the data memory sees it, data already on its lanes.
  typedef struct packed {
    logic        we;
    logic [3:0]  be;   // byte enables, bit 0 is the lowest address.
    logic [31:0] addr;
    logic [31:0] wd;
  } mem_req_t;

  // data memory access state.
  typedef enum logic {
    MEM_IDLE = 1'b0,
    MEM_BUSY = 1'b1
  } mem_state_e;

endpackage

`default_nettype wire

// File: src/riscv_lsu.sv
`default_nettype none

module riscv_lsu (
  input  logic              core_req_valid_i,
  input  lsu_pkg::core_req_t core_req_i,
  output logic [31:0]       core_rd_o,
  output logic              core_stall_o,
  output logic              mem_req_o,
  output mem_pkg::mem_req_t mem_o,
  input  logic [31:0]       mem_rd_i,
  input  logic              mem_ready_i
);

  import lsu_pkg::*;

  logic [1:0]  byte_off;  // byte lane within the word.
  logic        half_off;  // upper or lower halfword.
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;
  logic [3:0]  be;
  logic [31:0] wd_lanes;

  assign byte_off = core_req_i.addr[1:0];
  assign half_off = core_req_i.addr[1];

  // the core holds its request until the memory answers.
  assign core_stall_o = core_req_valid_i & ~mem_ready_i;
  assign mem_req_o    = core_req_valid_i;

  // store data lanes.
  always_comb begin
    case (core_req_i.size)
      LDST_B: begin
        wd_lanes = {4{core_req_i.wd[7:0]}};  // same byte on every lane.
      end
      LDST_H: begin
        wd_lanes = {2{core_req_i.wd[15:0]}};
      end
      LDST_W: begin
        wd_lanes = core_req_i.wd;
      end
      default: begin
        wd_lanes = '0;
      end
    endcase
  end

  // byte enables from size and the low address bits.
  always_comb begin
    case (core_req_i.size)
      LDST_B, LDST_BU: begin
        be = 4'b0001 << byte_off;
      end
      LDST_H, LDST_HU: begin
        be = half_off ? 4'b1100 : 4'b0011;
      end
      LDST_W: begin
        be = 4'b1111;
      end
      default: begin
        be = 4'b0000;  // unknown size touches nothing.
      end
    endcase
  end

  always_comb begin
    mem_o.we   = core_req_i.we;
    mem_o.be   = be;
    mem_o.addr = core_req_i.addr;
    mem_o.wd   = wd_lanes;
  end

  // pick the addressed byte and halfword out of the returned word.
  always_comb begin
    case (byte_off)
      2'd0:    rd_byte = mem_rd_i[7:0];
      2'd1:    rd_byte = mem_rd_i[15:8];
      2'd2:    rd_byte = mem_rd_i[23:16];
      default: rd_byte = mem_rd_i[31:24];
    endcase
    rd_half = half_off ? mem_rd_i[31:16] : mem_rd_i[15:0];
  end

  // load extension.
  always_comb begin
    case (core_req_i.size)
      LDST_B: begin
        core_rd_o = {{24{rd_byte[7]}}, rd_byte};  // sign.
      end
      LDST_H: begin
        core_rd_o = {{16{rd_half[15]}}, rd_half};
      end
      LDST_W: begin
        core_rd_o = mem_rd_i;
      end
      LDST_BU: begin
        core_rd_o = {24'd0, rd_byte};  // zeros.
      end
      LDST_HU: begin
        core_rd_o = {16'd0, rd_half};
      end
      default: begin
        core_rd_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/data_mem.sv
`default_nettype none

module data_mem #(
  parameter int unsigned MEM_WORDS   = 256, // depth in 32-bit words.
  parameter int unsigned MEM_LATENCY = 2    // request to ready, the registered read needs 2.
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              mem_req_i,
  input  mem_pkg::mem_req_t mem_i,
  output logic [31:0]       mem_rd_o,
  output logic              mem_ready_o
);

  import mem_pkg::*;

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int unsigned CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(MEM_LATENCY - 1);

  logic [31:0] ram [MEM_WORDS];

  mem_state_e       state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;   // cycle index within the access.
  logic             ready_d;
  logic [IDX_W-1:0] word_idx;
  logic [31:0]      rd_q;

  // word address wraps around the array.
  assign word_idx = IDX_W'(mem_i.addr[31:2] % MEM_WORDS);
  assign mem_rd_o = rd_q;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    ready_d = 1'b0;
    case (state_q)
      MEM_IDLE: begin
        if (mem_req_i) begin
          state_d = MEM_BUSY;
          cnt_d   = CNT_W'(1);     // first request cycle was index 0.
          ready_d = (cnt_d == LAST);
        end else begin
          cnt_d = '0;
        end
      end
      MEM_BUSY: begin
        if (mem_ready_o) begin
          state_d = MEM_IDLE;      // access ends with this ready.
          cnt_d   = '0;
        end else begin
          cnt_d   = cnt_q + 1'b1;
          ready_d = (cnt_d == LAST);
        end
      end
      default: begin
        state_d = MEM_IDLE;
        cnt_d   = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= MEM_IDLE;
      cnt_q       <= '0;
      mem_ready_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      mem_ready_o <= ready_d; // one-cycle pulse.
    end
  end

  // registered read, lands together with ready.
  always_ff @(posedge clk_i) begin
    if (ready_d) begin
      rd_q <= ram[word_idx];
    end
  end

  // store commits at the ready edge, enabled lanes only.
  always_ff @(posedge clk_i) begin
    if (mem_ready_o && mem_req_i && mem_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_i.be[b]) begin
          ram[word_idx][8*b +: 8] <= mem_i.wd[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_subsystem.sv
`default_nettype none

module lsu_subsystem #(
  parameter int unsigned MEM_WORDS   = 256,
  parameter int unsigned MEM_LATENCY = 2
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               core_req_valid_i,
  input  lsu_pkg::core_req_t core_req_i,
  output logic [31:0]        core_rd_o,
  output logic               core_stall_o
);

  import mem_pkg::*;

  // lsu to memory.
  logic        mem_req;
  mem_req_t    mem_bus;
  logic [31:0] mem_rd;
  logic        mem_ready;

  riscv_lsu u_lsu (
    .core_req_valid_i (core_req_valid_i),
    .core_req_i       (core_req_i),
    .core_rd_o        (core_rd_o),
    .core_stall_o     (core_stall_o),
    .mem_req_o        (mem_req),
    .mem_o            (mem_bus),
    .mem_rd_i         (mem_rd),
    .mem_ready_i      (mem_ready)
  );

  data_mem #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_mem (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_req_i   (mem_req),
    .mem_i       (mem_bus),
    .mem_rd_o    (mem_rd),
    .mem_ready_o (mem_ready)
  );

endmodule

`default_nettype wire

// File: verification/lsu_subsystem_sva.sv
`default_nettype none

module lsu_subsystem_sva (
  input logic                clk_i,
  input logic                rst_i,
  input logic                core_req_valid_i,
  input logic                core_stall_i,
  input logic                mem_ready_i,
  input mem_pkg::mem_state_e mem_state_i
);

  import mem_pkg::*;

  // a stalled request is still there in the next cycle.
  stall_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    core_stall_i |-> core_req_valid_i ##1 core_req_valid_i)
    else $error("stall raised without a request or request dropped during the stall");

  ready_single_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_ready_i |=> !mem_ready_i)
    else $error("memory ready held longer than one cycle");

  // first cycle out of reset.
  ready_low_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !mem_ready_i)
    else $error("memory ready high right after reset");

  busy_ends_with_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_state_i == MEM_IDLE && $past(mem_state_i) == MEM_BUSY) |-> $past(mem_ready_i))
    else $error("memory left busy state without a ready pulse");

endmodule

bind lsu_subsystem lsu_subsystem_sva u_sva (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .core_req_valid_i (core_req_valid_i),
  .core_stall_i     (core_stall_o),
  .mem_ready_i      (mem_ready),
  .mem_state_i      (u_mem.state_q)
);

`default_nettype wire

// File: verification/tb_lsu_subsystem.sv
`default_nettype none

module tb_lsu_subsystem;

  import lsu_pkg::*;

  localparam int unsigned MEM_WORDS     = 256;
  localparam int unsigned MEM_LATENCY   = 2;
  localparam int          STALL_TIMEOUT = 20;
  localparam int          RANDOM_OPS    = 400;

  logic        clk;
  logic        rst;
  logic        core_req_valid;
  core_req_t   core_req;
  logic [31:0] core_rd;
  logic        core_stall;

  logic [7:0]  model [64];  // byte image of the first 16 words.
  logic [31:0] rng;
  int          mismatches;
  int          timeouts;

  lsu_subsystem #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) uut (
    .clk_i            (clk),
    .rst_i            (rst),
    .core_req_valid_i (core_req_valid),
    .core_req_i       (core_req),
    .core_rd_o        (core_rd),
    .core_stall_o     (core_stall)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // distinct start value for every word address.
  function automatic logic [31:0] init_pattern(input logic [31:0] addr);
    return {addr[7:0] ^ 8'h3c, addr[7:0] + 8'h11, ~addr[7:0], addr[7:0] ^ 8'ha5}
           ^ {addr[31:8], 8'h00};
  endfunction

  // little endian with the lowest address in bits 7:0.
  function automatic logic [31:0] predict_load(input logic [31:0] addr, input ldst_size_e size);
    int          a;
    logic [31:0] v;
    a = int'(addr[5:0]);
    case (size)
      LDST_B:  v = {{24{model[a][7]}}, model[a]};
      LDST_BU: v = {24'd0, model[a]};
      LDST_H:  v = {{16{model[a+1][7]}}, model[a+1], model[a]};
      LDST_HU: v = {16'd0, model[a+1], model[a]};
      LDST_W:  v = {model[a+3], model[a+2], model[a+1], model[a]};
      default: v = '0;
    endcase
    return v;
  endfunction

  task automatic apply_store(input logic [31:0] addr, input ldst_size_e size,
                             input logic [31:0] wd);
    int a;
    a = int'(addr[5:0]);
    case (size)
      LDST_B: begin
        model[a] = wd[7:0];
      end
      LDST_H: begin
        model[a]   = wd[7:0];
        model[a+1] = wd[15:8];
      end
      LDST_W: begin
        for (int b = 0; b < 4; b++) begin
          model[a+b] = wd[8*b +: 8];
        end
      end
      default: begin
      end
    endcase
  endtask

  // one request, held until the stall falls.
  task automatic run_access(input logic we, input ldst_size_e size,
                            input logic [31:0] addr, input logic [31:0] wd);
    core_req_t   req;
    logic [31:0] expected;
    int          cycles;
    logic        done;
    req.we   = we;
    req.size = size;
    req.addr = addr;
    req.wd   = wd;
    expected = predict_load(addr, size);
    @(posedge clk);
    core_req_valid <= 1'b1;
    core_req       <= req;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < STALL_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (!core_stall) begin
        done = 1'b1;
      end
    end
    assert (done) else begin
      $display("ERROR: stall never fell within %0d cycles, address %h", STALL_TIMEOUT, addr);
      timeouts++;
    end
    if (done) begin
      assert (cycles == int'(MEM_LATENCY)) else begin
        $display("MISMATCH core_stall_o cycles: got %h expected %h", cycles, MEM_LATENCY);
        mismatches++;
      end
      if (we) begin
        apply_store(addr, size, wd);
      end else begin
        assert (core_rd === expected) else begin
          $display("MISMATCH core_rd_o: got %h expected %h (addr %h size %h)",
                   core_rd, expected, addr, size);
          mismatches++;
        end
      end
    end else begin
      @(posedge clk);
      core_req_valid <= 1'b0;
    end
  endtask

  // no request, so no stall.
  task automatic idle_cycle();
    @(posedge clk);
    core_req_valid <= 1'b0;
    @(negedge clk);
    assert (!core_stall) else begin
      $display("MISMATCH core_stall_o: got %h expected %h", core_stall, 1'b0);
      mismatches++;
    end
  endtask

  task automatic random_access();
    logic [31:0] r;
    logic [31:0] data;
    logic        we;
    ldst_size_e  size;
    logic [1:0]  low;
    rng = xorshift(rng);
    r   = rng;
    rng = xorshift(rng);
    data = rng;
    we   = r[0];
    if (we) begin
      case (r[2:1])
        2'd0:    size = LDST_B;
        2'd1:    size = LDST_H;
        default: size = LDST_W;
      endcase
    end else begin
      case (r[4:2])
        3'd0, 3'd5: size = LDST_B;
        3'd1, 3'd6: size = LDST_H;
        3'd2:       size = LDST_W;
        3'd3:       size = LDST_BU;
        default:    size = LDST_HU;
      endcase
    end
    low = r[10:9];
    if (size == LDST_H || size == LDST_HU) begin
      low[0] = 1'b0;
    end else if (size == LDST_W) begin
      low = 2'd0;
    end
    if (r[11]) begin
      data[15] = 1'b1;  // favor negative halfwords.
    end
    if (r[12]) begin
      data[7] = 1'b1;
    end
    run_access(we, size, {26'd0, r[8:5], low}, data);
    if (r[13]) begin
      idle_cycle();
    end
  endtask

  initial begin
    rst            = 1'b1;
    core_req_valid = 1'b0;
    core_req       = '0;
    rng            = 32'ha394;
    mismatches     = 0;
    timeouts       = 0;
    for (int i = 0; i < 64; i++) begin
      model[i] = 8'h00;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    idle_cycle();

    // known contents, then read back as words.
    for (int i = 0; i < 16; i++) begin
      run_access(1'b1, LDST_W, 32'(i * 4), init_pattern(32'(i * 4)));
    end
    for (int i = 0; i < 16; i++) begin
      run_access(1'b0, LDST_W, 32'(i * 4), 32'd0);
    end

    // byte lanes of word 5.
    for (int lane = 0; lane < 4; lane++) begin
      run_access(1'b1, LDST_B, 32'd20 + 32'(lane), 32'h0000_0080 | 32'(lane * 17));
      for (int k = 0; k < 4; k++) begin
        run_access(1'b0, LDST_BU, 32'd20 + 32'(k), 32'd0);
        run_access(1'b0, LDST_B, 32'd20 + 32'(k), 32'd0);
      end
    end

    // both halves of word 7, then mixed reads.
    run_access(1'b1, LDST_H, 32'd28, 32'h0000_8a5c);
    run_access(1'b1, LDST_H, 32'd30, 32'h0000_71f3);
    run_access(1'b0, LDST_H, 32'd28, 32'd0);
    run_access(1'b0, LDST_HU, 32'd28, 32'd0);
    run_access(1'b0, LDST_H, 32'd30, 32'd0);
    run_access(1'b0, LDST_HU, 32'd30, 32'd0);
    for (int k = 0; k < 4; k++) begin
      run_access(1'b0, LDST_B, 32'd28 + 32'(k), 32'd0);
      run_access(1'b0, LDST_BU, 32'd28 + 32'(k), 32'd0);
    end
    run_access(1'b0, LDST_W, 32'd28, 32'd0);

    for (int n = 0; n < RANDOM_OPS; n++) begin
      random_access();
    end
    idle_cycle();

    $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
src/lsu_pkg.sv
src/mem_pkg.sv
src/riscv_lsu.sv
src/data_mem.sv
src/lsu_subsystem.sv
verification/lsu_subsystem_sva.sv
verification/tb_lsu_subsystem.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_lsu_subsystem -f verilog.f \
  -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 ||
cat build.log
cat sim.log 2>/dev/null
grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
